//--- include/gbIo_defs.svh
`ifndef GB_IO_DEFS_SVH
`define GB_IO_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// I/O page register addresses
////////////////////////////////////////////////////////////////////////////
`define GB_ADDR_P1   16'hFF00
`define GB_ADDR_DIV  16'hFF04
`define GB_ADDR_TIMA 16'hFF05
`define GB_ADDR_TMA  16'hFF06
`define GB_ADDR_TAC  16'hFF07
`define GB_ADDR_IF   16'hFF0F
`define GB_ADDR_IE   16'hFFFF

// Interrupt bit positions inside IF and IE
`define GB_IRQ_TIMER  2
`define GB_IRQ_JOYPAD 4

// Divider bit used as the timer tap, per TAC[1:0] setting
`define GB_TAP_SEL00 9
`define GB_TAP_SEL01 3
`define GB_TAP_SEL10 5
`define GB_TAP_SEL11 7

// Flops in the button synchronizer
`define GB_SYNC_STAGES 2

`endif

//--- logic/gbIoPkg.sv
package gbIoPkg;

	typedef logic [15:0] ioAddr_t;
	typedef logic [7:0]  ioData_t;

	// One bit per source, VBlank in bit 0 up to joypad in bit 4
	typedef logic [4:0]  irqBits_t;
	typedef logic [2:0]  irqIndex_t;

	typedef struct packed {
		ioAddr_t addr;
		ioData_t writeData;
		logic    we;
		logic    readRequest;
	} cpuBus_t;

	// Write strobes are one-hot, all peripherals share the data byte
	typedef struct packed {
		logic    p1;
		logic    div;
		logic    tima;
		logic    tma;
		logic    tac;
		logic    iFlag;
		logic    iEnable;
		ioData_t data;
	} regWrite_t;

	typedef struct packed {
		ioData_t div;
		ioData_t tima;
		ioData_t tma;
		ioData_t tac;
	} timerRegs_t;

	typedef struct packed {
		irqBits_t iFlag;
		irqBits_t iEnable;
	} irqStatus_t;

endpackage

//--- logic/ioRegisterMap.sv
`timescale 1ns/1ps
`include "gbIo_defs.svh"

module ioRegisterMap (
	input  logic                clock,
	input  logic                rstN,
	input  gbIoPkg::cpuBus_t    bus,
	input  gbIoPkg::timerRegs_t timerRegs,
	input  gbIoPkg::ioData_t    p1Value,
	input  gbIoPkg::irqStatus_t irqStatus,
	output gbIoPkg::regWrite_t  regWrite,
	output gbIoPkg::ioData_t    readData,
	output logic                readValid
);

	gbIoPkg::ioData_t readMux;
	logic [6:0] strobeVec;

	////////////////////////////////////////////////////////////////////////////
	// Write decode
	////////////////////////////////////////////////////////////////////////////

	// Strobes follow the bus directly, peripherals latch on the same edge
	always_comb begin
		regWrite         = '0;
		regWrite.data    = bus.writeData;
		regWrite.p1      = bus.we && (bus.addr == `GB_ADDR_P1);
		regWrite.div     = bus.we && (bus.addr == `GB_ADDR_DIV);
		regWrite.tima    = bus.we && (bus.addr == `GB_ADDR_TIMA);
		regWrite.tma     = bus.we && (bus.addr == `GB_ADDR_TMA);
		regWrite.tac     = bus.we && (bus.addr == `GB_ADDR_TAC);
		regWrite.iFlag   = bus.we && (bus.addr == `GB_ADDR_IF);
		regWrite.iEnable = bus.we && (bus.addr == `GB_ADDR_IE);
	end

	assign strobeVec = {regWrite.p1, regWrite.div, regWrite.tima, regWrite.tma,
		regWrite.tac, regWrite.iFlag, regWrite.iEnable};

	////////////////////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (bus.addr)
			`GB_ADDR_P1:   readMux = p1Value;
			`GB_ADDR_DIV:  readMux = timerRegs.div;
			`GB_ADDR_TIMA: readMux = timerRegs.tima;
			`GB_ADDR_TMA:  readMux = timerRegs.tma;
			`GB_ADDR_TAC:  readMux = timerRegs.tac;
			// Only five interrupt sources exist, upper bits float high
			`GB_ADDR_IF:   readMux = {3'b111, irqStatus.iFlag};
			`GB_ADDR_IE:   readMux = {3'b111, irqStatus.iEnable};
			default:       readMux = 8'hFF;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			readValid <= 1'b0;
		end else begin
			readValid <= bus.readRequest;
		end
	end

	// Holds the last value read until the next request
	always_ff @(posedge clock) begin
		if (bus.readRequest) begin
			readData <= readMux;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// The CPU issues at most one access per cycle
	singleAccess: assert property (@(posedge clock) disable iff (!rstN)
		!(bus.we && bus.readRequest))
		else $error("write and read request high together");

	strobeOneHot: assert property (@(posedge clock) disable iff (!rstN)
		$onehot0(strobeVec))
		else $error("more than one register write strobe active");

endmodule

//--- logic/interruptController.sv
`timescale 1ns/1ps

module interruptController (
	input  logic                 clock,
	input  logic                 rstN,
	input  gbIoPkg::regWrite_t   regWrite,
	input  gbIoPkg::irqBits_t    requests,
	output gbIoPkg::irqStatus_t  irqStatus,
	output gbIoPkg::irqBits_t    irqPending,
	output gbIoPkg::irqIndex_t   irqIndex,
	output logic                 irqValid
);

	gbIoPkg::irqBits_t iFlag;
	gbIoPkg::irqBits_t iEnable;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			iFlag   <= '0;
			iEnable <= '0;
		end else begin
			// A request arriving with an IF write still gets recorded
			if (regWrite.iFlag) begin
				iFlag <= regWrite.data[4:0] | requests;
			end else begin
				iFlag <= iFlag | requests;
			end
			if (regWrite.iEnable) begin
				iEnable <= regWrite.data[4:0];
			end
		end
	end

	assign irqStatus.iFlag   = iFlag;
	assign irqStatus.iEnable = iEnable;
	assign irqPending        = iFlag & iEnable;
	assign irqValid          = |irqPending;

	// Lowest bit wins, so VBlank has top priority
	always_comb begin
		irqIndex = '0;
		for (int i = 4; i >= 0; i--) begin
			if (irqPending[i]) begin
				irqIndex = i[2:0];
			end
		end
	end

	// The index names a pending source with nothing pending below it
	indexIsLowestPending: assert property (@(posedge clock) disable iff (!rstN)
		irqValid |-> (irqPending[irqIndex] &&
			((irqPending & ((5'd1 << irqIndex) - 5'd1)) == '0)))
		else $error("irqIndex is not the lowest pending source");

endmodule

//--- logic/divTimer.sv
`timescale 1ns/1ps
`include "gbIo_defs.svh"

module divTimer (
	input  logic                clock,
	input  logic                rstN,
	input  gbIoPkg::regWrite_t  regWrite,
	output gbIoPkg::timerRegs_t timerRegs,
	output logic                timerIrq
);

	logic [15:0] counter;
	gbIoPkg::ioData_t tima;
	gbIoPkg::ioData_t tma;
	logic [2:0] tacBits;
	logic tapBit;
	logic tapNow;
	logic tapPrev;
	logic tick;

	////////////////////////////////////////////////////////////////////////////
	// Free-running divider
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rstN) begin
			counter <= '0;
		end else if (regWrite.div) begin
			// Any DIV write resets the whole prescaler, not just the top byte
			counter <= '0;
		end else begin
			counter <= counter + 16'd1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Tap select and edge detect
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (tacBits[1:0])
			2'b00:   tapBit = counter[`GB_TAP_SEL00];
			2'b01:   tapBit = counter[`GB_TAP_SEL01];
			2'b10:   tapBit = counter[`GB_TAP_SEL10];
			default: tapBit = counter[`GB_TAP_SEL11];
		endcase
	end

	assign tapNow = tapBit & tacBits[2];
	assign tick   = tapPrev & ~tapNow & tacBits[2];

	always_ff @(posedge clock) begin
		if (!rstN) begin
			tapPrev <= 1'b0;
		end else begin
			tapPrev <= tapNow;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// TIMA, TMA, TAC
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rstN) begin
			tima     <= '0;
			tma      <= '0;
			tacBits  <= '0;
			timerIrq <= 1'b0;
		end else begin
			timerIrq <= tick && (tima == 8'hFF);
			// CPU write to TIMA takes precedence over a tick
			if (regWrite.tima) begin
				tima <= regWrite.data;
			end else if (tick) begin
				tima <= (tima == 8'hFF) ? tma : tima + 8'd1;
			end
			if (regWrite.tma) begin
				tma <= regWrite.data;
			end
			if (regWrite.tac) begin
				tacBits <= regWrite.data[2:0];
			end
		end
	end

	assign timerRegs.div  = counter[15:8];
	assign timerRegs.tima = tima;
	assign timerRegs.tma  = tma;
	assign timerRegs.tac  = {5'b11111, tacBits};

	// Ticks are at least 16 cycles apart so a reload never repeats back to back
	irqSinglePulse: assert property (@(posedge clock) disable iff (!rstN)
		timerIrq |=> !timerIrq)
		else $error("timerIrq held for more than one cycle");

endmodule

//--- logic/joypad.sv
`timescale 1ns/1ps
`include "gbIo_defs.svh"

module joypad (
	input  logic               clock,
	input  logic               rstN,
	input  gbIoPkg::regWrite_t regWrite,
	input  logic [7:0]         buttons,
	output gbIoPkg::ioData_t   p1Value,
	output logic               joypadIrq
);

	logic [7:0] syncChain [`GB_SYNC_STAGES];
	logic [7:0] pressed;
	logic [1:0] selectN;
	logic [3:0] dirGroup;
	logic [3:0] actGroup;
	logic [3:0] lowNibble;
	logic [3:0] nibblePrev;

	// Buttons are asynchronous to the core clock
	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < `GB_SYNC_STAGES; i++) begin
				syncChain[i] <= '0;
			end
			pressed <= '0;
		end else begin
			syncChain[0] <= buttons;
			for (int i = 1; i < `GB_SYNC_STAGES; i++) begin
				syncChain[i] <= syncChain[i-1];
			end
			pressed <= syncChain[`GB_SYNC_STAGES-1];
		end
	end

	// P5 selects actions, P4 selects directions, both active low
	always_ff @(posedge clock) begin
		if (!rstN) begin
			selectN    <= 2'b11;
			nibblePrev <= 4'hF;
		end else begin
			if (regWrite.p1) begin
				selectN <= regWrite.data[5:4];
			end
			nibblePrev <= lowNibble;
		end
	end

	assign dirGroup  = selectN[0] ? 4'h0 : pressed[3:0];
	assign actGroup  = selectN[1] ? 4'h0 : pressed[7:4];
	assign lowNibble = ~(dirGroup | actGroup);
	assign p1Value   = {2'b11, selectN, lowNibble};

	// High-to-low on any selected line, as on the real port
	assign joypadIrq = |(nibblePrev & ~lowNibble);

endmodule

//--- logic/gbIoSubsystem.sv
`timescale 1ns/1ps
`include "gbIo_defs.svh"

module gbIoSubsystem (
	input  logic                clock,
	input  logic                rstN,
	input  gbIoPkg::cpuBus_t    bus,
	input  logic [7:0]          buttons,
	output gbIoPkg::ioData_t    readData,
	output logic                readValid,
	output gbIoPkg::irqBits_t   irqPending,
	output gbIoPkg::irqIndex_t  irqIndex,
	output logic                irqValid
);

	gbIoPkg::regWrite_t  regWrite;
	gbIoPkg::timerRegs_t timerRegs;
	gbIoPkg::irqStatus_t irqStatus;
	gbIoPkg::ioData_t    p1Value;
	gbIoPkg::irqBits_t   requests;
	logic timerIrq;
	logic joypadIrq;

	// VBlank, STAT and serial live outside this block
	always_comb begin
		requests                 = '0;
		requests[`GB_IRQ_TIMER]  = timerIrq;
		requests[`GB_IRQ_JOYPAD] = joypadIrq;
	end

	ioRegisterMap regMap0 (
		.clock     (clock),
		.rstN      (rstN),
		.bus       (bus),
		.timerRegs (timerRegs),
		.p1Value   (p1Value),
		.irqStatus (irqStatus),
		.regWrite  (regWrite),
		.readData  (readData),
		.readValid (readValid)
	);

	divTimer timer0 (
		.clock     (clock),
		.rstN      (rstN),
		.regWrite  (regWrite),
		.timerRegs (timerRegs),
		.timerIrq  (timerIrq)
	);

	joypad joypad0 (
		.clock     (clock),
		.rstN      (rstN),
		.regWrite  (regWrite),
		.buttons   (buttons),
		.p1Value   (p1Value),
		.joypadIrq (joypadIrq)
	);

	interruptController intCtrl0 (
		.clock      (clock),
		.rstN       (rstN),
		.regWrite   (regWrite),
		.requests   (requests),
		.irqStatus  (irqStatus),
		.irqPending (irqPending),
		.irqIndex   (irqIndex),
		.irqValid   (irqValid)
	);

endmodule

//--- verification/gbIoTb.sv
`timescale 1ns/1ps
`include "gbIo_defs.svh"

module gbIoTb;

	localparam logic [2:0] opWrite    = 3'd0;
	localparam logic [2:0] opRead     = 3'd1;
	localparam logic [2:0] opPress    = 3'd2;
	localparam logic [2:0] opWaitIrq  = 3'd3;
	localparam logic [2:0] opIrqCheck = 3'd4;
	localparam logic [2:0] opWaitDiv  = 3'd5;
	localparam int readTimeout = 8;
	localparam int irqTimeout  = 200;
	localparam int divTimeout  = 600;

	// In an IRQ check step expLo holds the pending mask and expHi the top index
	typedef struct packed {
		logic [2:0]       op;
		gbIoPkg::ioAddr_t addr;
		gbIoPkg::ioData_t data;
		gbIoPkg::ioData_t expLo;
		gbIoPkg::ioData_t expHi;
	} step_t;

	logic clock;
	logic rstN;
	gbIoPkg::cpuBus_t bus;
	logic [7:0] buttons;
	gbIoPkg::ioData_t readData;
	logic readValid;
	gbIoPkg::irqBits_t irqPending;
	gbIoPkg::irqIndex_t irqIndex;
	logic irqValid;

	step_t steps[$];
	int cycleCount;
	int checkCount;
	int errorCount;
	int unsigned seedDiscard;
	step_t s;
	gbIoPkg::ioData_t got;
	logic ok;
	int errorsBefore;
	gbIoPkg::ioData_t rTma;
	gbIoPkg::ioData_t rTac;
	gbIoPkg::ioData_t rIe;
	gbIoPkg::ioData_t rIf;

	gbIoSubsystem dut0 (
		.clock      (clock),
		.rstN       (rstN),
		.bus        (bus),
		.buttons    (buttons),
		.readData   (readData),
		.readValid  (readValid),
		.irqPending (irqPending),
		.irqIndex   (irqIndex),
		.irqValid   (irqValid)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus and check helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic string regName(input gbIoPkg::ioAddr_t addr);
		case (addr)
			`GB_ADDR_P1:   return "P1";
			`GB_ADDR_DIV:  return "DIV";
			`GB_ADDR_TIMA: return "TIMA";
			`GB_ADDR_TMA:  return "TMA";
			`GB_ADDR_TAC:  return "TAC";
			`GB_ADDR_IF:   return "IF";
			`GB_ADDR_IE:   return "IE";
			default:       return "unmapped";
		endcase
	endfunction

	function automatic string opName(input logic [2:0] op);
		case (op)
			opWrite:    return "write";
			opRead:     return "read";
			opPress:    return "press";
			opWaitIrq:  return "waitIrq";
			opIrqCheck: return "irqCheck";
			default:    return "waitDiv";
		endcase
	endfunction

	function automatic void addStep(input logic [2:0] op, input gbIoPkg::ioAddr_t addr,
			input gbIoPkg::ioData_t data, input gbIoPkg::ioData_t lo,
			input gbIoPkg::ioData_t hi);
		steps.push_back(step_t'{op, addr, data, lo, hi});
	endfunction

	task automatic writeReg(input gbIoPkg::ioAddr_t addr, input gbIoPkg::ioData_t data);
		@(negedge clock);
		bus.addr      = addr;
		bus.writeData = data;
		bus.we        = 1'b1;
		@(negedge clock);
		bus.we = 1'b0;
	endtask

	// readValid must rise exactly one cycle after the request
	task automatic readReg(input gbIoPkg::ioAddr_t addr, output gbIoPkg::ioData_t data,
			output logic valid);
		int waited;
		@(negedge clock);
		bus.addr        = addr;
		bus.readRequest = 1'b1;
		@(negedge clock);
		bus.readRequest = 1'b0;
		waited = 1;
		while (!readValid && waited < readTimeout) begin
			@(negedge clock);
			waited++;
		end
		valid = readValid;
		data  = readData;
		checkCount++;
		assert (valid && waited == 1) else begin
			if (!valid) begin
				$display("Timeout: no readValid for read of %h", addr);
			end else begin
				$display("readValid for %h came %0d cycles after the request", addr, waited);
			end
			errorCount++;
		end
	endtask

	task automatic checkRange(input string name, input gbIoPkg::ioData_t value,
			input gbIoPkg::ioData_t lo, input gbIoPkg::ioData_t hi);
		checkCount++;
		assert (value >= lo && value <= hi) else begin
			if (lo == hi) begin
				$display("** Error: readData from %s = %h, expected %h", name, value, lo);
			end else begin
				$display("** Error: readData from %s = %h, expected %h to %h",
					name, value, lo, hi);
			end
			errorCount++;
		end
	endtask

	task automatic pressButtons(input logic [7:0] value);
		@(negedge clock);
		buttons = value;
		// Synchronizer latency plus one cycle of margin
		repeat (`GB_SYNC_STAGES + 2) @(negedge clock);
	endtask

	task automatic waitRegBit(input gbIoPkg::ioAddr_t addr, input logic [2:0] bitIndex,
			input int limit);
		gbIoPkg::ioData_t value;
		logic valid;
		logic seen;
		int start;
		start = cycleCount;
		seen  = 1'b0;
		while (!seen && (cycleCount - start) < limit) begin
			readReg(addr, value, valid);
			seen = valid && value[bitIndex];
		end
		checkCount++;
		assert (seen) else begin
			$display("Timeout: %s bit %0d not set within %0d cycles", regName(addr),
				bitIndex, limit);
			errorCount++;
		end
	endtask

	task automatic checkIrq(input gbIoPkg::irqBits_t pending, input gbIoPkg::irqIndex_t index);
		logic expValid;
		@(negedge clock);
		expValid = (pending != '0);
		checkCount++;
		assert (irqPending == pending) else begin
			$display("** Error: irqPending = %h, expected %h", irqPending, pending);
			errorCount++;
		end
		checkCount++;
		assert (irqValid == expValid) else begin
			$display("** Error: irqValid = %h, expected %h", irqValid, expValid);
			errorCount++;
		end
		if (expValid) begin
			checkCount++;
			assert (irqIndex == index) else begin
				$display("** Error: irqIndex = %h, expected %h", irqIndex, index);
				errorCount++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic buildTable();
		rTma = 8'($urandom());
		rTac = 8'($urandom());
		rIe  = 8'($urandom());
		rIf  = 8'($urandom());
		// Reset values and unmapped space
		addStep(opRead, `GB_ADDR_IF, 8'h00, 8'hE0, 8'hE0);
		addStep(opRead, `GB_ADDR_IE, 8'h00, 8'hE0, 8'hE0);
		addStep(opRead, `GB_ADDR_TAC, 8'h00, 8'hF8, 8'hF8);
		addStep(opRead, `GB_ADDR_P1, 8'h00, 8'hFF, 8'hFF);
		addStep(opRead, `GB_ADDR_TIMA, 8'h00, 8'h00, 8'h00);
		addStep(opRead, `GB_ADDR_TMA, 8'h00, 8'h00, 8'h00);
		addStep(opRead, 16'hFF10, 8'h00, 8'hFF, 8'hFF);
		addStep(opWrite, 16'hFF10, 8'h5A, 8'h00, 8'h00);
		addStep(opRead, 16'hFF10, 8'h00, 8'hFF, 8'hFF);
		// IF and IE keep five bits through a round trip and TAC keeps three
		addStep(opWrite, `GB_ADDR_TMA, rTma, 8'h00, 8'h00);
		addStep(opRead, `GB_ADDR_TMA, 8'h00, rTma, rTma);
		addStep(opWrite, `GB_ADDR_TAC, rTac, 8'h00, 8'h00);
		addStep(opRead, `GB_ADDR_TAC, 8'h00, rTac | 8'hF8, rTac | 8'hF8);
		addStep(opWrite, `GB_ADDR_IE, rIe, 8'h00, 8'h00);
		addStep(opRead, `GB_ADDR_IE, 8'h00, rIe | 8'hE0, rIe | 8'hE0);
		addStep(opWrite, `GB_ADDR_IF, rIf, 8'h00, 8'h00);
		addStep(opRead, `GB_ADDR_IF, 8'h00, rIf | 8'hE0, rIf | 8'hE0);
		// Let DIV count away from zero before it is cleared
		addStep(opWaitDiv, `GB_ADDR_DIV, 8'h00, 8'h00, 8'h00);
		addStep(opWrite, `GB_ADDR_DIV, rTma, 8'h00, 8'h00);
		addStep(opRead, `GB_ADDR_DIV, 8'h00, 8'h00, 8'h00);
		// Timer overflow into IF bit 2
		addStep(opWrite, `GB_ADDR_TAC, 8'h00, 8'h00, 8'h00);
		addStep(opWrite, `GB_ADDR_TMA, 8'h80, 8'h00, 8'h00);
		addStep(opWrite, `GB_ADDR_TIMA, 8'hFE, 8'h00, 8'h00);
		addStep(opWrite, `GB_ADDR_IF, 8'h00, 8'h00, 8'h00);
		addStep(opWrite, `GB_ADDR_IE, 8'h04, 8'h00, 8'h00);
		addStep(opWrite, `GB_ADDR_TAC, 8'h05, 8'h00, 8'h00);
		addStep(opWaitIrq, 16'h0000, 8'(`GB_IRQ_TIMER), 8'h00, 8'h00);
		addStep(opRead, `GB_ADDR_TIMA, 8'h00, 8'h80, 8'h82);
		addStep(opIrqCheck, 16'h0000, 8'h00, 8'h04, 8'h02);
		addStep(opWrite, `GB_ADDR_TAC, 8'h00, 8'h00, 8'h00);
		addStep(opWrite, `GB_ADDR_IF, 8'h00, 8'h00, 8'h00);
		// Joypad with directions selected and then with actions selected
		addStep(opWrite, `GB_ADDR_P1, 8'h20, 8'h00, 8'h00);
		addStep(opPress, `GB_ADDR_P1, 8'h01, 8'hEE, 8'hEE);
		addStep(opWaitIrq, 16'h0000, 8'(`GB_IRQ_JOYPAD), 8'h00, 8'h00);
		addStep(opRead, `GB_ADDR_IF, 8'h00, 8'hF0, 8'hF0);
		addStep(opPress, `GB_ADDR_P1, 8'h00, 8'hEF, 8'hEF);
		addStep(opWrite, `GB_ADDR_IF, 8'h00, 8'h00, 8'h00);
		addStep(opWrite, `GB_ADDR_P1, 8'h10, 8'h00, 8'h00);
		addStep(opPress, `GB_ADDR_P1, 8'h01, 8'hDF, 8'hDF);
		addStep(opRead, `GB_ADDR_IF, 8'h00, 8'hE0, 8'hE0);
		addStep(opPress, `GB_ADDR_P1, 8'h00, 8'hDF, 8'hDF);
		// Priority between timer and joypad and then clearing
		addStep(opWrite, `GB_ADDR_IE, 8'h1F, 8'h00, 8'h00);
		addStep(opWrite, `GB_ADDR_IF, 8'h14, 8'h00, 8'h00);
		addStep(opIrqCheck, 16'h0000, 8'h00, 8'h14, 8'h02);
		addStep(opRead, `GB_ADDR_IF, 8'h00, 8'hF4, 8'hF4);
		addStep(opWrite, `GB_ADDR_IF, 8'h00, 8'h00, 8'h00);
		addStep(opIrqCheck, 16'h0000, 8'h00, 8'h00, 8'h00);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		bus        = '0;
		buttons    = '0;
		rstN       = 1'b0;
		cycleCount = 0;
		checkCount = 0;
		errorCount = 0;
		seedDiscard = $urandom(32'h385c);
		buildTable();
		repeat (4) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;

		foreach (steps[i]) begin
			s = steps[i];
			errorsBefore = errorCount;
			case (s.op)
				opWrite: writeReg(s.addr, s.data);
				opRead: begin
					readReg(s.addr, got, ok);
					if (ok) begin
						checkRange(regName(s.addr), got, s.expLo, s.expHi);
					end
				end
				opPress: begin
					pressButtons(s.data);
					readReg(`GB_ADDR_P1, got, ok);
					if (ok) begin
						checkRange("P1", got, s.expLo, s.expHi);
					end
				end
				opWaitIrq: waitRegBit(`GB_ADDR_IF, s.data[2:0], irqTimeout);
				opWaitDiv: waitRegBit(`GB_ADDR_DIV, 3'd0, divTimeout);
				default: checkIrq(s.expLo[4:0], s.expHi[2:0]);
			endcase
			$display("step %0d %s %h data %h: %s", i, opName(s.op), s.addr, s.data,
				(errorCount == errorsBefore) ? "ok" : "FAILED");
		end

		$display("Summary: %0d steps, %0d checks, %0d errors",
			steps.size(), checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+include
logic/gbIoPkg.sv
logic/ioRegisterMap.sv
logic/interruptController.sv
logic/divTimer.sv
logic/joypad.sv
logic/gbIoSubsystem.sv
verification/gbIoTb.sv

//--- run.sh
#!/bin/sh
# Builds the I/O block testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
	-f sources.f \
	--top-module gbIoTb \
	--Mdir "$BUILD_DIR" \
	-o gbIoSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/gbIoSim" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Verification failed" "$LOG"; then
	exit 1
fi

exit 0
